// ==== test/program_input.txt ====
# I <instruction word>, one per word address from 0
# S <section> <store address> <store data>, in expected order
# section 1 arithmetic and logic
I FF900093
I 02300113
I 002081B3
I 40208233
I 002092B3
I 0020D333
I 4020D3B3
I 0020A433
I 0020B4B3
I 0020C533
I 0020E5B3
I 0020F633
I FFA0A693
I 02413713
I 0F00C793
I 4010D813
I 00411893
I 01C0D913
I 07F0F993
I F0016A13
I 10302023
I 10402223
I 10502423
I 10602623
I 10702823
I 10802A23
I 10902C23
I 10A02E23
I 12B02023
I 12C02223
I 12D02423
I 12E02623
I 12F02823
I 13002A23
I 13102C23
I 13202E23
I 15302023
I 15402223
# section 2 memory round trip
I 10002A83
I 10402B03
I 016A8BB3
I 15702423
I 14802C03
I 064C0C13
I 15802623
I 20000C93
I FF8CAE23
# section 3 branches, taken then not taken for each condition
I 05A00D13
I 0BD00D93
I 00210463
I 1FB02823
I 00208463
I 19A02023
I 00209463
I 1FB02823
I 00211463
I 19A02223
I 0020C463
I 1FB02823
I 00114463
I 19A02423
I 00115463
I 1FB02823
I 0020D463
I 19A02623
I 00116463
I 1FB02823
I 0020E463
I 19A02823
I 0020F463
I 1FB02823
I 00117463
I 19A02A23
# section 4 jal and jalr, jalr target has bit 0 set
I 00800E6F
I 1FB02823
I 1BC02023
I 14100E93
I 000E8F67
I 1FB02823
I 1FB02823
I 1BE02223
# section 5 lui and auipc, then halt and a squashed store
I ABCDEFB7
I 12345297
I 1BF02423
I 1A502623
I FFFFFFFF
I 1FB02823
S 1 00000100 0000001C
S 1 00000104 FFFFFFD6
S 1 00000108 FFFFFFC8
S 1 0000010C 1FFFFFFF
S 1 00000110 FFFFFFFF
S 1 00000114 00000001
S 1 00000118 00000000
S 1 0000011C FFFFFFDA
S 1 00000120 FFFFFFFB
S 1 00000124 00000021
S 1 00000128 00000001
S 1 0000012C 00000001
S 1 00000130 FFFFFF09
S 1 00000134 FFFFFFFC
S 1 00000138 00000230
S 1 0000013C 0000000F
S 1 00000140 00000079
S 1 00000144 FFFFFF23
S 2 00000148 FFFFFFF2
S 2 0000014C 00000056
S 2 000001FC 00000056
S 3 00000180 0000005A
S 3 00000184 0000005A
S 3 00000188 0000005A
S 3 0000018C 0000005A
S 3 00000190 0000005A
S 3 00000194 0000005A
S 4 000001A0 00000128
S 4 000001A4 00000138
S 5 000001A8 ABCDE000
S 5 000001AC 12345148

// ==== all.f ====
rtl/cpu_types_pkg.sv
rtl/fetch_unit.sv
rtl/if_id.sv
rtl/register_file.sv
rtl/alu.sv
rtl/control_unit.sv
rtl/execute_stage.sv
rtl/datapath.sv
test/datapath_sva.sv
test/datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module datapath_tb \
  -Mdir obj_dir -o datapath_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/datapath_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// ==== test/datapath_tb.sv ====
`timescale 1ns/1ps

module datapath_tb;
  import cpu_types_pkg::*;

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 1024;

  logic  CLK;
  logic  nRST;
  word_t imemload;
  word_t dmemload;
  word_t imemaddr;
  word_t dmemaddr;
  word_t dmemstore;
  logic  imemREN;
  logic  dmemREN;
  logic  dmemWEN;
  logic  halt;

  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  int    prog_len;

  // expected stores in program order, tagged with their section
  int    exp_sec[$];
  word_t exp_addr[$];
  word_t exp_data[$];

  int    errors;
  int    passes;
  int    cycles;
  int    limit;
  int    cur_sec;
  int    sec_err_base;
  bit    timed_out;

  datapath datapath_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .imemload  (imemload),
    .dmemload  (dmemload),
    .imemaddr  (imemaddr),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .imemREN   (imemREN),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .halt      (halt)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // memories answer only while their read strobe is high
  // reads past the end of the program see the halt word
  assign imemload = !imemREN ? '0 :
                    ({2'b00, imemaddr[31:2]} < word_t'(prog_len)) ?
                    imem[imemaddr[9:2]] : HALT_INSTR;
  assign dmemload = dmemREN ? dmem[dmemaddr[11:2]] : '0;

  always @(posedge CLK)
  begin
    if (dmemWEN)
    begin
      dmem[dmemaddr[11:2]] <= dmemstore;
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
    else
    begin
      passes++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
    else
    begin
      passes++;
    end
  endtask

  task automatic report_section(input int sec);
    if (errors == sec_err_base)
    begin
      $display("section %0d: ok", sec);
    end
    else
    begin
      $display("section %0d: %0d errors", sec, errors - sec_err_base);
    end
    sec_err_base = errors;
  endtask

  // I lines hold program words, S lines hold section, address and data
  task automatic load_program();
    int    fd;
    int    code;
    int    sec;
    word_t a;
    word_t d;
    string line;
    fd = $fopen("test/program_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open test/program_input.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        if (code > 2 && line.getc(0) == "I")
        begin
          code = $sscanf(line.substr(1, line.len() - 1), "%h", d);
          if (prog_len < IMEM_WORDS)
          begin
            imem[prog_len] = d;
            prog_len++;
          end
        end
        else if (code > 2 && line.getc(0) == "S")
        begin
          code = $sscanf(line.substr(1, line.len() - 1), "%d %h %h", sec, a, d);
          exp_sec.push_back(sec);
          exp_addr.push_back(a);
          exp_data.push_back(d);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic take_store();
    int    sec;
    word_t a;
    word_t d;
    if (exp_addr.size() == 0)
    begin
      $display("store of %h to %h when no store was expected", dmemstore, dmemaddr);
      errors++;
    end
    else
    begin
      sec = exp_sec.pop_front();
      a   = exp_addr.pop_front();
      d   = exp_data.pop_front();
      if (sec != cur_sec)
      begin
        report_section(cur_sec);
        cur_sec = sec;
      end
      check_word("dmemaddr", a, dmemaddr);
      check_word("dmemstore", d, dmemstore);
    end
  endtask

  initial
  begin
    int halt_err_base;
    nRST      = 1'b0;
    prog_len  = 0;
    errors    = 0;
    passes    = 0;
    cycles    = 0;
    timed_out = 1'b0;
    for (int i = 0; i < DMEM_WORDS; i++)
    begin
      dmem[i] = '0;
    end
    load_program();
    limit = prog_len * 8 + 20;
    cur_sec = (exp_sec.size() > 0) ? exp_sec[0] : 1;
    sec_err_base = errors;

    repeat (4) @(posedge CLK);
    #1 nRST = 1'b1;

    // sample at the falling edge, away from register updates
    while (!halt && !timed_out)
    begin
      @(negedge CLK);
      cycles++;
      if (dmemWEN)
      begin
        take_store();
      end
      if (!halt && cycles >= limit)
      begin
        timed_out = 1'b1;
      end
    end
    report_section(cur_sec);

    halt_err_base = errors;
    if (timed_out)
    begin
      $display("halt never rose within %0d cycles", limit);
      errors++;
    end
    repeat (5)
    begin
      @(negedge CLK);
      check_bit("halt", 1'b1, halt);
      check_bit("dmemWEN", 1'b0, dmemWEN);
      check_bit("imemREN", 1'b0, imemREN);
    end
    if (exp_addr.size() != 0)
    begin
      $display("%0d expected stores never happened", exp_addr.size());
      errors++;
    end
    if (errors == halt_err_base)
    begin
      $display("halt: ok");
    end
    else
    begin
      $display("halt: %0d errors", errors - halt_err_base);
    end

    $display("checks passed: %0d, errors: %0d", passes, errors);
    if (errors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== test/datapath_sva.sv ====
`timescale 1ns/1ps

module datapath_sva (
  input logic                 CLK,
  input logic                 nRST,
  input cpu_types_pkg::word_t imemaddr,
  input logic                 imemREN,
  input logic                 dmemREN,
  input logic                 dmemWEN,
  input logic                 halt
);

  // one data access per cycle
  no_read_and_write: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN))
    else $error("dmemREN and dmemWEN high together");

  // halt is sticky and everything goes quiet behind it
  halt_holds: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> (halt && !imemREN && !dmemREN && !dmemWEN))
    else $error("activity or halt drop after halt");

  quiet_in_reset: assert property (@(posedge CLK)
    !nRST |-> (!dmemREN && !dmemWEN && !halt))
    else $error("strobe or halt high during reset");

  pc_aligned: assert property (@(posedge CLK)
    imemaddr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

endmodule

bind datapath datapath_sva datapath_sva_i (
  .CLK      (CLK),
  .nRST     (nRST),
  .imemaddr (imemaddr),
  .imemREN  (imemREN),
  .dmemREN  (dmemREN),
  .dmemWEN  (dmemWEN),
  .halt     (halt)
);

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps

module datapath (
  input  logic                 CLK,
  input  logic                 nRST,
  input  cpu_types_pkg::word_t imemload,
  input  cpu_types_pkg::word_t dmemload,
  output cpu_types_pkg::word_t imemaddr,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 imemREN,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  output logic                 halt
);
  import cpu_types_pkg::*;

  instr_t instr;
  word_t  instr_pc;
  word_t  target;
  logic   valid;
  logic   redirect;
  logic   flush;

  // pc goes straight out as the instruction address
  fetch_unit fetch_unit_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .redirect (redirect),
    .target   (target),
    .halt     (halt),
    .pc       (imemaddr),
    .imemREN  (imemREN)
  );

  if_id if_id_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .imemload (imemload),
    .pc       (imemaddr),
    .flush    (flush),
    .halt     (halt),
    .instr    (instr),
    .instr_pc (instr_pc),
    .valid    (valid)
  );

  execute_stage execute_stage_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .instr     (instr),
    .instr_pc  (instr_pc),
    .valid     (valid),
    .dmemload  (dmemload),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .redirect  (redirect),
    .flush     (flush),
    .target    (target),
    .halt      (halt)
  );

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  cpu_types_pkg::instr_t instr,
  input  cpu_types_pkg::word_t  instr_pc,
  input  logic                  valid,
  input  cpu_types_pkg::word_t  dmemload,
  output cpu_types_pkg::word_t  dmemaddr,
  output cpu_types_pkg::word_t  dmemstore,
  output logic                  dmemREN,
  output logic                  dmemWEN,
  output logic                  redirect,
  output logic                  flush,
  output cpu_types_pkg::word_t  target,
  output logic                  halt
);
  import cpu_types_pkg::*;

  aluop_t    alu_op;
  rd_sel_t   rd_sel;
  funct3_b_t cond;
  regbits_t  rs1;
  regbits_t  rs2;
  regbits_t  rd;
  word_t     imm;
  word_t     rdat1;
  word_t     rdat2;
  word_t     wdat;
  word_t     port_b;
  word_t     alu_out;
  logic      alu_src;
  logic      reg_wr;
  logic      d_ren;
  logic      d_wen;
  logic      branch;
  logic      jump;
  logic      jump_reg;
  logic      halt_op;
  logic      zero;
  logic      taken;

  assign rs1  = instr.r.rs1;
  assign rs2  = instr.r.rs2;
  assign rd   = instr.r.rd;
  assign cond = funct3_b_t'(instr.b.funct3);

  control_unit control_unit_i (
    .instr    (instr),
    .alu_op   (alu_op),
    .alu_src  (alu_src),
    .reg_wr   (reg_wr),
    .d_ren    (d_ren),
    .d_wen    (d_wen),
    .branch   (branch),
    .jump     (jump),
    .jump_reg (jump_reg),
    .halt_op  (halt_op),
    .rd_sel   (rd_sel),
    .imm      (imm)
  );

  register_file register_file_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (valid & reg_wr),
    .wsel  (rd),
    .rsel1 (rs1),
    .rsel2 (rs2),
    .wdat  (wdat),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  assign port_b = alu_src ? imm : rdat2;

  alu alu_i (
    .alu_op   (alu_op),
    .port_a   (rdat1),
    .port_b   (port_b),
    .port_out (alu_out),
    .zero     (zero)
  );

  // write-back source
  always_comb
  begin
    case (rd_sel)
      MEM:     wdat = dmemload;
      NPC:     wdat = instr_pc + 32'd4;
      UIMM:    wdat = imm;
      PCUIMM:  wdat = instr_pc + imm;
      default: wdat = alu_out;
    endcase
  end

  // branch outcome from the alu result
  always_comb
  begin
    case (cond)
      BEQ:         taken = zero;
      BNE:         taken = ~zero;
      BLT, BLTU:   taken = alu_out[0];
      BGE, BGEU:   taken = ~alu_out[0];
      default:     taken = 1'b0;
    endcase
  end

  // jalr drops bit 0 of the sum
  assign target = jump_reg ? {alu_out[31:1], 1'b0} : instr_pc + imm;

  assign redirect = valid & (jump | jump_reg | (branch & taken));
  // the slot behind a halt word is squashed as well
  assign flush    = redirect | (valid & halt_op);

  assign dmemaddr  = alu_out;
  assign dmemstore = rdat2;
  assign dmemREN   = valid & d_ren;
  assign dmemWEN   = valid & d_wen;

  // sticky once the halt word retires
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      halt <= 1'b0;
    end
    else
    begin
      halt <= halt | (valid & halt_op);
    end
  end

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  cpu_types_pkg::instr_t  instr,
  output cpu_types_pkg::aluop_t  alu_op,
  output logic                   alu_src,
  output logic                   reg_wr,
  output logic                   d_ren,
  output logic                   d_wen,
  output logic                   branch,
  output logic                   jump,
  output logic                   jump_reg,
  output logic                   halt_op,
  output cpu_types_pkg::rd_sel_t rd_sel,
  output cpu_types_pkg::word_t   imm
);
  import cpu_types_pkg::*;

  // shared by R and I formats; addi never becomes sub
  function automatic aluop_t alu_decode(
    input logic [2:0] f3,
    input logic       alt,
    input logic       sub_ok
  );
    aluop_t op;
    case (f3)
      F3_ADDSUB: op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
      F3_SLL:    op = ALU_SLL;
      F3_SLT:    op = ALU_SLT;
      F3_SLTU:   op = ALU_SLTU;
      F3_XOR:    op = ALU_XOR;
      F3_SR:     op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:     op = ALU_OR;
      default:   op = ALU_AND;
    endcase
    return op;
  endfunction

  logic alt;

  assign alt     = (instr.r.funct7 == F7_ALT);
  assign halt_op = (instr == HALT_INSTR);

  always_comb
  begin
    alu_op   = ALU_ADD;
    alu_src  = 1'b0;
    reg_wr   = 1'b0;
    d_ren    = 1'b0;
    d_wen    = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    jump_reg = 1'b0;
    rd_sel   = ALU;
    imm      = {{20{instr.i.imm[11]}}, instr.i.imm};

    case (instr.r.opcode)
      RTYPE:
      begin
        alu_op = alu_decode(instr.r.funct3, alt, 1'b1);
        reg_wr = 1'b1;
      end
      ITYPE:
      begin
        alu_op  = alu_decode(instr.i.funct3, alt, 1'b0);
        alu_src = 1'b1;
        reg_wr  = 1'b1;
      end
      LOAD:
      begin
        alu_src = 1'b1;
        reg_wr  = 1'b1;
        d_ren   = 1'b1;
        rd_sel  = MEM;
      end
      STORE:
      begin
        alu_src = 1'b1;
        d_wen   = 1'b1;
        imm     = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      end
      BRANCH:
      begin
        branch = 1'b1;
        imm    = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
        // equality by subtraction, ordering by set-less-than
        case (instr.b.funct3[2:1])
          2'b10:   alu_op = ALU_SLT;
          2'b11:   alu_op = ALU_SLTU;
          default: alu_op = ALU_SUB;
        endcase
      end
      JAL:
      begin
        jump   = 1'b1;
        reg_wr = 1'b1;
        rd_sel = NPC;
        imm    = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};
      end
      JALR:
      begin
        jump_reg = 1'b1;
        alu_src  = 1'b1;
        reg_wr   = 1'b1;
        rd_sel   = NPC;
      end
      LUI:
      begin
        reg_wr = 1'b1;
        rd_sel = UIMM;
        imm    = {instr.u.imm, 12'd0};
      end
      AUIPC:
      begin
        reg_wr = 1'b1;
        rd_sel = PCUIMM;
        imm    = {instr.u.imm, 12'd0};
      end
      default:
      begin
        // halt word and unknown opcodes do nothing
        alu_op = ALU_ADD;
      end
    endcase
  end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::aluop_t alu_op,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  port_out,
  output logic                  zero
);
  import cpu_types_pkg::*;

  logic [4:0] shamt;

  // shifts only look at the low five bits
  assign shamt = port_b[4:0];

  always_comb
  begin
    case (alu_op)
      ALU_SLL:
      begin
        port_out = port_a << shamt;
      end
      ALU_SRL:
      begin
        port_out = port_a >> shamt;
      end
      ALU_SRA:
      begin
        port_out = word_t'($signed(port_a) >>> shamt);
      end
      ALU_SUB:
      begin
        port_out = port_a - port_b;
      end
      ALU_AND:
      begin
        port_out = port_a & port_b;
      end
      ALU_OR:
      begin
        port_out = port_a | port_b;
      end
      ALU_XOR:
      begin
        port_out = port_a ^ port_b;
      end
      ALU_SLT:
      begin
        port_out = {31'd0, $signed(port_a) < $signed(port_b)};
      end
      ALU_SLTU:
      begin
        port_out = {31'd0, port_a < port_b};
      end
      default:
      begin
        port_out = port_a + port_b;
      end
    endcase
  end

  assign zero = (port_out == '0);

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  input  cpu_types_pkg::word_t    wdat,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  word_t regs [32];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wen && (wsel != 5'd0))
    begin
      // x0 never takes a write
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

// ==== rtl/if_id.sv ====
`timescale 1ns/1ps

module if_id (
  input  logic                  CLK,
  input  logic                  nRST,
  input  cpu_types_pkg::word_t  imemload,
  input  cpu_types_pkg::word_t  pc,
  input  logic                  flush,
  input  logic                  halt,
  output cpu_types_pkg::instr_t instr,
  output cpu_types_pkg::word_t  instr_pc,
  output logic                  valid
);
  import cpu_types_pkg::*;

  // slot state and the address of the held word
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid    <= 1'b0;
      instr_pc <= PC_INIT;
    end
    else
    begin
      // flush or halt turns the slot into a bubble
      valid    <= ~(flush | halt);
      instr_pc <= pc;
    end
  end

  // fetched word, only meaningful while valid
  always_ff @(posedge CLK)
  begin
    instr <= instr_t'(imemload);
  end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 redirect,
  input  cpu_types_pkg::word_t target,
  input  logic                 halt,
  output cpu_types_pkg::word_t pc,
  output logic                 imemREN
);
  import cpu_types_pkg::*;

  word_t next_pc;

  // halt wins, then a taken transfer, then the next word
  always_comb
  begin
    if (halt)
    begin
      next_pc = pc;
    end
    else if (redirect)
    begin
      next_pc = target;
    end
    else
    begin
      next_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc <= PC_INIT;
    end
    else
    begin
      pc <= next_pc;
    end
  end

  // no more fetches once stopped
  assign imemREN = ~halt;

endmodule

// ==== rtl/cpu_types_pkg.sv ====
package cpu_types_pkg;

  localparam int WORD_W = 32;
  localparam int REG_W  = 5;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  regbits_t;

  // reset pc and the stop word
  localparam word_t PC_INIT    = 32'h0000_0000;
  localparam word_t HALT_INSTR = 32'hffff_ffff;

  // funct3 codes for the alu group
  localparam logic [2:0] F3_ADDSUB = 3'b000;
  localparam logic [2:0] F3_SLL    = 3'b001;
  localparam logic [2:0] F3_SLT    = 3'b010;
  localparam logic [2:0] F3_SLTU   = 3'b011;
  localparam logic [2:0] F3_XOR    = 3'b100;
  localparam logic [2:0] F3_SR     = 3'b101;
  localparam logic [2:0] F3_OR     = 3'b110;
  localparam logic [2:0] F3_AND    = 3'b111;

  // funct7 pattern for sub and sra
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef enum logic [6:0] {
    RTYPE  = 7'b0110011,
    ITYPE  = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } funct3_b_t;

  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } aluop_t;

  typedef enum logic [2:0] {
    ALU,
    MEM,
    NPC,
    UIMM,
    PCUIMM
  } rd_sel_t;

  // one struct per encoding format, all 32 bits wide
  typedef struct packed {
    logic [6:0] funct7;
    regbits_t   rs2;
    regbits_t   rs1;
    logic [2:0] funct3;
    regbits_t   rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    regbits_t    rs1;
    logic [2:0]  funct3;
    regbits_t    rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    regbits_t   rs2;
    regbits_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    regbits_t   rs2;
    regbits_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    regbits_t    rd;
    opcode_t     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    regbits_t   rd;
    opcode_t    opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_t;

endpackage
